// ==== project.f ====
+incdir+rtl
rtl/rob_idx_pkg.sv
rtl/rob_payload_pkg.sv
rtl/rob_wr_if.sv
rtl/dualport_ram.sv
rtl/lutram_fifo.sv
rtl/rob_ctrl.sv
rtl/rob_data.sv
rtl/rob_top.sv
test/tb_rob.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the reorder buffer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f project.f \
    --top-module tb_rob \
    --Mdir obj_dir \
    -o sim_tb_rob

./obj_dir/sim_tb_rob | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

// ==== test/tb_rob.sv ====
// Reorder buffer testbench
`timescale 1ns/10ps
`default_nettype none

`include "rob_defs.svh"

module tb_rob
    import rob_idx_pkg::*, rob_payload_pkg::*;
();

    localparam int CAPACITY = `ROB_ENTRIES - `ROB_MIN_FREE_SLOTS;
    // Entries pushed through by all tests together
    localparam int TEST_ENTRIES = 8 + 8 + 12 + CAPACITY + 40;
    // Alloc, write, pipeline wait, stalls and idle gaps, with margin
    localparam int CYCLES_PER_ENTRY = 32;
    localparam int TIMEOUT_CYCLES = 100 + TEST_ENTRIES * CYCLES_PER_ENTRY;

    logic      clk;
    logic      reset;
    logic      alloc;
    t_rob_meta alloc_meta;
    logic      not_full;
    t_rob_idx  alloc_idx;
    logic      wr_en;
    t_rob_idx  wr_idx;
    t_rob_data wr_data;
    logic      deq;
    logic      not_empty;
    t_rob_data first;
    t_rob_meta first_meta;

    int    errors = 0;
    int    checks = 0;
    int    seed = 1651;
    int    cycle_count = 0;
    // Expected alloc_idx, wraps with the ring
    int    next_idx = 0;
    // Source of distinct metadata
    int    serial = 0;
    int    count;
    string test_name;

    // Reference model in allocation order
    t_rob_meta exp_meta [$];
    t_rob_data exp_data [$];
    // Data to write per slot, chosen at allocation
    t_rob_data slot_data [`ROB_ENTRIES];
    int        batch_slot [`ROB_ENTRIES];
    int        order [`ROB_ENTRIES];

    initial clk = 1'b0;
    always #4 clk = ~clk;

    rob_top UUT (
        .clk        (clk),
        .reset      (reset),
        .alloc      (alloc),
        .alloc_meta (alloc_meta),
        .not_full   (not_full),
        .alloc_idx  (alloc_idx),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .wr_data    (wr_data),
        .deq        (deq),
        .not_empty  (not_empty),
        .first      (first),
        .first_meta (first_meta)
    );

    // Watchdog
    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, the DUT stopped delivering entries",
                     cycle_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
        checks++;
        assert (actual == expected)
        else
        begin
            errors++;
            $display("[ERROR] %s: %s expected %h, actual %h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic idle(int n);
        repeat (n) @(negedge clk);
    endtask

    // One allocation, returns the slot the DUT handed out
    task automatic alloc_slot(output int slot);
        t_rob_data d;
        d = $random(seed);
        check_value("not_full before alloc", 32'd1, 32'(not_full));
        @(posedge clk);
        alloc      <= 1'b1;
        alloc_meta <= t_rob_meta'(serial);
        // Index is valid in the alloc cycle
        @(negedge clk);
        slot = int'(alloc_idx);
        check_value("alloc_idx", 32'(next_idx), 32'(alloc_idx));
        @(posedge clk);
        alloc <= 1'b0;
        @(negedge clk);
        exp_meta.push_back(t_rob_meta'(serial));
        exp_data.push_back(d);
        slot_data[slot] = d;
        serial++;
        next_idx = (next_idx + 1) % `ROB_ENTRIES;
    endtask

    task automatic write_slot(int slot);
        @(posedge clk);
        wr_en   <= 1'b1;
        wr_idx  <= t_rob_idx'(slot);
        wr_data <= slot_data[slot];
        @(posedge clk);
        wr_en <= 1'b0;
        @(negedge clk);
    endtask

    // Wait for the head entry, compare it, then pop it
    task automatic pop_check();
        t_rob_meta want_meta;
        t_rob_data want_data;
        while (!not_empty)
        begin
            @(negedge clk);
        end
        want_meta = exp_meta.pop_front();
        want_data = exp_data.pop_front();
        check_value("first_meta", 32'(want_meta), 32'(first_meta));
        check_value("first", want_data, first);
        @(posedge clk);
        deq <= 1'b1;
        @(posedge clk);
        deq <= 1'b0;
        @(negedge clk);
    endtask

    // Write order: 0 in order, 1 reversed, 2 shuffled
    task automatic run_batch(int n, int mode, int stall);
        int k;
        int j;
        int tmp;
        for (k = 0; k < n; k++)
        begin
            alloc_slot(batch_slot[k]);
            order[k] = (mode == 1) ? n - 1 - k : k;
        end
        if (mode == 2)
        begin
            // Fisher-Yates shuffle
            for (k = n - 1; k > 0; k--)
            begin
                j = ($random(seed) & 32'h7fff_ffff) % (k + 1);
                tmp = order[k];
                order[k] = order[j];
                order[j] = tmp;
            end
        end
        for (k = 0; k < n; k++)
        begin
            if (order[k] == 0)
            begin
                // Give younger entries time to leak out if ordering were broken
                if (mode == 1)
                    idle(8);
                check_value("not_empty before oldest write", 32'd0, 32'(not_empty));
            end
            write_slot(batch_slot[order[k]]);
        end
        for (k = 0; k < n; k++)
        begin
            if (stall != 0)
                idle($random(seed) & 3);
            pop_check();
        end
    endtask

    initial
    begin
        reset      <= 1'b1;
        alloc      <= 1'b0;
        alloc_meta <= '0;
        wr_en      <= 1'b0;
        wr_idx     <= '0;
        wr_data    <= '0;
        deq        <= 1'b0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        test_name = "reset_state";
        // Control valid bits leave reset one cycle late
        idle(3);
        check_value("not_empty", 32'd0, 32'(not_empty));
        check_value("not_full", 32'd1, 32'(not_full));
        check_value("oldest_deq", 32'd0, 32'(UUT.oldest_deq));

        test_name = "in_order";
        run_batch(8, 0, 0);

        test_name = "reverse_order";
        run_batch(8, 1, 0);

        test_name = "random_stalls";
        run_batch(12, 2, 1);

        test_name = "full_recovery";
        count = 0;
        while (not_full && count < `ROB_ENTRIES)
        begin
            alloc_slot(batch_slot[count]);
            count++;
        end
        check_value("accepted allocations", 32'(CAPACITY), 32'(count));
        check_value("not_full when full", 32'd0, 32'(not_full));
        for (int k = 0; k < count; k++)
        begin
            write_slot(batch_slot[k]);
        end
        for (int k = 0; k < count; k++)
        begin
            pop_check();
        end
        idle(2);
        check_value("not_full after drain", 32'd1, 32'(not_full));

        // Four batches of ten cross the index wrap more than twice
        test_name = "wraparound";
        for (int b = 0; b < 4; b++)
        begin
            run_batch(10, 2, b % 2);
        end
        // A duplicated entry would still sit in the output FIFO
        idle(8);
        check_value("not_empty after drain", 32'd0, 32'(not_empty));

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/rob_top.sv ====
// Reorder buffer top level
`timescale 1ns/10ps
`default_nettype none

module rob_top
    import rob_idx_pkg::*, rob_payload_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset,
    // Allocation
    input  wire logic      alloc,
    input  wire t_rob_meta alloc_meta,
    output logic           not_full,
    output t_rob_idx       alloc_idx,
    // Out-of-order data write
    input  wire logic      wr_en,
    input  wire t_rob_idx  wr_idx,
    input  wire t_rob_data wr_data,
    // Ordered output
    input  wire logic      deq,
    output logic           not_empty,
    output t_rob_data      first,
    output t_rob_meta      first_meta
);

    // Oldest-entry link between control and data
    logic     oldest_deq;
    logic     oldest_rdy;
    t_rob_idx oldest_idx;

    rob_wr_if wr_bus ();

    assign wr_bus.alloc      = alloc;
    assign wr_bus.alloc_meta = alloc_meta;
    assign wr_bus.wr_en      = wr_en;
    assign wr_bus.wr_idx     = wr_idx;
    assign wr_bus.wr_data    = wr_data;

    // Slot index comes back from control
    assign alloc_idx = wr_bus.alloc_idx;

    rob_ctrl ctrl (
        .clk        (clk),
        .reset      (reset),
        .wr         (wr_bus.ctrl),
        .oldest_deq (oldest_deq),
        .not_full   (not_full),
        .oldest_rdy (oldest_rdy),
        .oldest_idx (oldest_idx)
    );

    rob_data data (
        .clk        (clk),
        .reset      (reset),
        .wr         (wr_bus.data),
        .deq        (deq),
        .oldest_rdy (oldest_rdy),
        .oldest_idx (oldest_idx),
        .oldest_deq (oldest_deq),
        .not_empty  (not_empty),
        .first      (first),
        .first_meta (first_meta)
    );

endmodule

`default_nettype wire

// ==== rtl/rob_data.sv ====
// Reorder buffer data path
`timescale 1ns/10ps
`default_nettype none

`include "rob_defs.svh"

module rob_data
    import rob_idx_pkg::*, rob_payload_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    rob_wr_if.data        wr,
    input  wire logic     deq,
    input  wire logic     oldest_rdy,
    input  wire t_rob_idx oldest_idx,
    output logic          oldest_deq,
    output logic          not_empty,
    output t_rob_data     first,
    output t_rob_meta     first_meta
);

    t_rob_meta  mem_meta;
    t_rob_data  mem_data;
    t_rob_entry fifo_in;
    t_rob_entry fifo_out;

    logic fifo_almost_full;

    // RAM read in flight, one flag per pipeline stage
    logic did_deq;
    logic did_deq_q;

    // Move the oldest entry only while the FIFO can absorb
    // everything already in flight
    assign oldest_deq = oldest_rdy && !fifo_almost_full;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            did_deq   <= 1'b0;
            did_deq_q <= 1'b0;
        end
        else
        begin
            did_deq   <= oldest_deq;
            did_deq_q <= did_deq;
        end
    end

    // Metadata is stored at allocation
    dualport_ram #(
        .t_payload (t_rob_meta),
        .N_ENTRIES (`ROB_ENTRIES)
    ) meta_ram (
        .clk     (clk),
        .wr_addr (wr.alloc_idx),
        .wr_en   (wr.alloc),
        .wr_data (wr.alloc_meta),
        .rd_addr (oldest_idx),
        .rd_data (mem_meta)
    );

    // Data lands in any order
    dualport_ram #(
        .t_payload (t_rob_data),
        .N_ENTRIES (`ROB_ENTRIES)
    ) data_ram (
        .clk     (clk),
        .wr_addr (wr.wr_idx),
        .wr_en   (wr.wr_en),
        .wr_data (wr.wr_data),
        .rd_addr (oldest_idx),
        .rd_data (mem_data)
    );

    assign fifo_in = '{meta: mem_meta, data: mem_data};

    // FIFO decouples client deq from the RAM read loop
    lutram_fifo #(
        .t_payload (t_rob_entry),
        .N_ENTRIES (`ROB_FIFO_ENTRIES),
        .THRESHOLD (`ROB_FIFO_THRESHOLD)
    ) out_fifo (
        .clk         (clk),
        .reset       (reset),
        .enq_en      (did_deq_q),
        .enq_data    (fifo_in),
        .deq_en      (deq),
        .almost_full (fifo_almost_full),
        .not_empty   (not_empty),
        .first       (fifo_out)
    );

    assign first      = fifo_out.data;
    assign first_meta = fifo_out.meta;

endmodule

`default_nettype wire

// ==== rtl/rob_ctrl.sv ====
// Reorder buffer control
`timescale 1ns/10ps
`default_nettype none

`include "rob_defs.svh"

module rob_ctrl
    import rob_idx_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset,
    rob_wr_if.ctrl    wr,
    input  wire logic oldest_deq,
    output logic      not_full,
    output logic      oldest_rdy,
    output t_rob_idx  oldest_idx
);

    // Next slot to allocate
    t_rob_idx newest;
    // Oldest slot still owned by the ROB
    t_rob_idx oldest;
    t_rob_idx oldest_next;

    logic newest_ge_oldest;

    // Per-slot data arrival
    logic [`ROB_ENTRIES-1:0] dvalid;
    logic [`ROB_ENTRIES-1:0] dvalid_q;

    // Valid bits of the oldest slot and the one after it
    logic [1:0] dvalid_sub_q;
    logic       oldest_deq_q;
    t_rob_idx   oldest_q;

    // Delayed reset for the wide valid vector
    logic reset_q;

    assign oldest_next = oldest + t_rob_idx'(1);
    assign oldest_idx  = oldest;

    // Allocation returns the current newest slot
    assign wr.alloc_idx = newest;

    // Full test in the wider space
    // Oldest gets an extra high bit when newest has not wrapped past it
    assign newest_ge_oldest = (newest >= oldest);
    assign not_full = ({1'b0, newest} + t_rob_idx_nowrap'(`ROB_MIN_FREE_SLOTS))
                      < {newest_ge_oldest, oldest};

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            newest <= '0;
            oldest <= '0;
        end
        else
        begin
            if (wr.alloc)
            begin
                newest <= newest + t_rob_idx'(1);
            end
            // Oldest moves once its entry heads into the data pipeline
            if (oldest_deq)
            begin
                oldest <= oldest_next;
            end
        end
    end

    always_comb
    begin
        dvalid = dvalid_q;
        // Clear the slot dequeued last cycle
        if (oldest_deq_q)
        begin
            dvalid[oldest_q] = 1'b0;
        end
        // Arriving data sets its slot
        if (wr.wr_en)
        begin
            dvalid[wr.wr_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        reset_q <= reset;
    end

    always_ff @(posedge clk)
    begin
        if (reset_q)
        begin
            dvalid_q     <= '0;
            dvalid_sub_q <= 2'b00;
            oldest_deq_q <= 1'b0;
        end
        else
        begin
            dvalid_q     <= dvalid;
            oldest_deq_q <= oldest_deq;
            // Snapshot both candidates for next cycle
            dvalid_sub_q <= {dvalid_q[oldest_next], dvalid_q[oldest]};
        end
        oldest_q <= oldest;
    end

    // After a dequeue the next slot becomes the oldest
    // so pick the upper snapshot bit
    assign oldest_rdy = dvalid_sub_q[oldest_deq_q];

endmodule

`default_nettype wire

// ==== rtl/lutram_fifo.sv ====
// Small show-ahead FIFO
`timescale 1ns/10ps
`default_nettype none

module lutram_fifo #(
    parameter type t_payload = logic [31:0],
    parameter int  N_ENTRIES = 4,
    parameter int  THRESHOLD = 2
) (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     enq_en,
    input  wire t_payload enq_data,
    input  wire logic     deq_en,
    output logic          almost_full,
    output logic          not_empty,
    output t_payload      first
);

    localparam int PTR_BITS = $clog2(N_ENTRIES);
    localparam int CNT_BITS = $clog2(N_ENTRIES + 1);

    // Storage, no reset needed
    t_payload mem [N_ENTRIES];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    // Occupancy
    logic [CNT_BITS-1:0] count;

    always_ff @(posedge clk)
    begin
        if (enq_en)
        begin
            mem[wr_ptr] <= enq_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (enq_en)
            begin
                wr_ptr <= wr_ptr + PTR_BITS'(1);
            end
            if (deq_en)
            begin
                rd_ptr <= rd_ptr + PTR_BITS'(1);
            end
            // Count moves only when one side acts alone
            case ({enq_en, deq_en})
                2'b10:   count <= count + CNT_BITS'(1);
                2'b01:   count <= count - CNT_BITS'(1);
                default: count <= count;
            endcase
        end
    end

    // Head word shown without a read strobe
    assign first = mem[rd_ptr];

    assign not_empty = (count != '0);

    // Leaves room for words already in flight upstream
    assign almost_full = (count >= CNT_BITS'(THRESHOLD));

endmodule

`default_nettype wire

// ==== rtl/dualport_ram.sv ====
// Pipelined dual-port RAM
`timescale 1ns/10ps
`default_nettype none

module dualport_ram #(
    parameter type t_payload = logic [31:0],
    parameter int  N_ENTRIES = 16
) (
    input  wire logic                         clk,
    input  wire logic [$clog2(N_ENTRIES)-1:0] wr_addr,
    input  wire logic                         wr_en,
    input  wire t_payload                     wr_data,
    input  wire logic [$clog2(N_ENTRIES)-1:0] rd_addr,
    output t_payload                          rd_data
);

    t_payload mem [N_ENTRIES];

    // Registered read word
    t_payload rd_q;

    // Write port
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read port, address to rd_data takes two cycles
    always_ff @(posedge clk)
    begin
        rd_q    <= mem[rd_addr];
        // Output stage
        rd_data <= rd_q;
    end

endmodule

`default_nettype wire

// ==== rtl/rob_wr_if.sv ====
// Reorder buffer write bus
`timescale 1ns/10ps
`default_nettype none

interface rob_wr_if
    import rob_idx_pkg::*, rob_payload_pkg::*;
();

    // Slot allocation with its metadata
    logic      alloc;
    t_rob_idx  alloc_idx;
    t_rob_meta alloc_meta;

    // Data write into an already allocated slot
    logic      wr_en;
    t_rob_idx  wr_idx;
    t_rob_data wr_data;

    // Control only needs the strobes and the write index
    modport ctrl (input alloc, input wr_en, input wr_idx, output alloc_idx);

    // Data side stores metadata and data
    modport data (input alloc, input alloc_idx, input alloc_meta,
                  input wr_en, input wr_idx, input wr_data);

endinterface

`default_nettype wire

// ==== rtl/rob_payload_pkg.sv ====
// Reorder buffer payload types
`default_nettype none

`include "rob_defs.svh"

package rob_payload_pkg;

    // Late-arriving data word
    typedef logic [`ROB_DATA_BITS-1:0] t_rob_data;

    // Metadata supplied with the allocation
    typedef logic [`ROB_META_BITS-1:0] t_rob_meta;

    // Joined entry held in the output FIFO
    typedef struct packed {
        t_rob_meta meta;
        t_rob_data data;
    } t_rob_entry;

endpackage

`default_nettype wire

// ==== rtl/rob_idx_pkg.sv ====
// Reorder buffer index types
`default_nettype none

`include "rob_defs.svh"

package rob_idx_pkg;

    // Slot index into the ring
    typedef logic [$clog2(`ROB_ENTRIES)-1:0] t_rob_idx;

    // One extra bit so pointers can be compared
    // after one of them has wrapped
    typedef logic [$clog2(`ROB_ENTRIES):0] t_rob_idx_nowrap;

endpackage

`default_nettype wire

// ==== rtl/rob_defs.svh ====
// Reorder buffer sizing
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// Slot count of the ring, power of 2 only
`define ROB_ENTRIES 16
`define ROB_DATA_BITS 32
`define ROB_META_BITS 8

// not_full drops when fewer than this many slots remain
`define ROB_MIN_FREE_SLOTS 1

// Output FIFO depth and the occupancy that stops new transfers
`define ROB_FIFO_ENTRIES 4
`define ROB_FIFO_THRESHOLD 2

`endif
